/* tb.f */
+incdir+verification
common/mipsPkg.sv
stageID/controller.sv
stageID/regFile.sv
stageID/stageID.sv
design/stageIF.sv
design/stageEX.sv
design/stageMEM.sv
design/mipsCore.sv
verification/tbCore.sv

/* verification/tbRefModel.svh */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

logic [DATA_WIDTH-1:0]           regModel [32];            // Architectural registers
logic [DATA_WIDTH-1:0]           memModel [DMEM_WORDS];    // Architectural data memory
logic [REG_WIDTH+DATA_WIDTH-1:0] expWb [$];                // {dest, data} in write-back order
logic [2*DATA_WIDTH-1:0]         expMem [$];               // {addr, data} in store order

// A write to r0 is still seen on the write-back port, only the register keeps zero
function automatic void recordWrite(input logic [REG_WIDTH-1:0] dest,
                                    input logic [DATA_WIDTH-1:0] value);
    expWb.push_back({dest, value});
    if (dest != 0)
        regModel[dest] = value;
endfunction

// Runs one program from word zero until the PC falls off its end
function automatic void interpretProgram(input int t);
    logic [DATA_WIDTH-1:0] w;
    logic [DATA_WIDTH-1:0] a;
    logic [DATA_WIDTH-1:0] b;
    logic [DATA_WIDTH-1:0] imm;
    logic [DATA_WIDTH-1:0] addr;
    int                    pc;
    int                    nextPc;
    int                    pending;
    int                    target;
    int                    steps;
    pc      = 0;
    pending = 0;
    target  = 0;
    steps   = 0;
    while (pc >= 0 && pc < progLen[t] && steps < 4 * MAX_PROG) begin
        w      = progs[t][pc];
        a      = regModel[w[25:21]];                        // rs
        b      = regModel[w[20:16]];                        // rt
        imm    = {{16{w[15]}}, w[15:0]};
        addr   = a + imm;
        nextPc = pc + 1;
        if (pending > 0) begin                              // Counting down the delay slots
            pending--;
            if (pending == 0)
                nextPc = target;
        end
        case (w[31:26])
            opRType: begin
                case (w[5:0])
                    fnAdd:   recordWrite(w[15:11], a + b);
                    fnSub:   recordWrite(w[15:11], a - b);
                    fnAnd:   recordWrite(w[15:11], a & b);
                    fnOr:    recordWrite(w[15:11], a | b);
                    fnSlt:   recordWrite(w[15:11], ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
                    default: ;                              // Nop
                endcase
            end
            opAddi: recordWrite(w[20:16], addr);
            opLw:   recordWrite(w[20:16], memModel[(addr >> 2) % DMEM_WORDS]);
            opSw: begin
                expMem.push_back({addr, b});
                memModel[(addr >> 2) % DMEM_WORDS] = b;
            end
            opBeq: begin
                if (a == b) begin
                    pending = 2;
                    target  = pc + 1 + $signed(imm);        // Word index of the target
                end
            end
            default: ;
        endcase
        pc = nextPc;
        steps++;
    end
endfunction

`endif

/* verification/tbCore.sv */
`timescale 1ns/100ps

module tbCore;
    import mipsPkg::*;

    localparam int NUM_TESTS = 6;
    localparam int MAX_PROG  = 64;
    localparam int PAD       = 16;                          // Nops loaded past each program
    localparam int RAND_LEN  = 40;

    logic                  clk;
    logic                  rst;
    logic                  run;
    logic                  imemWe;
    logic [ADDR_WIDTH-1:0] imemAddr;
    instWordT              imemData;
    wbT                    wb;
    memWrT                 memWr;

    logic [DATA_WIDTH-1:0] progs [NUM_TESTS][MAX_PROG];
    int                    progLen [NUM_TESTS];
    int                    lastWrite [9];                   // Last write slot in random test or -1
    instFnT                aluFns [5] = '{fnAdd, fnSub, fnAnd, fnOr, fnSlt};
    string                 testNames [NUM_TESTS] = '{"R-type ALU", "addi sign", "sw/lw",
                                                     "beq slots", "r0 writes", "random"};
    integer                seed = 32'h5860ae6e;
    int                    testErrors;
    int                    passCount;
    int                    failCount;
    int                    watchLimit;                      // In ns
    bit                    watchArmed;

    `include "tbRefModel.svh"

    mipsCore i_dut (
        .i_clk      (clk),
        .i_rst      (rst),
        .i_run      (run),
        .i_imemWe   (imemWe),
        .i_imemAddr (imemAddr),
        .i_imemData (imemData),
        .o_wb       (wb),
        .o_memWr    (memWr)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] rWord(input instFnT fn, input int rd, input int rs,
                                          input int rt);
        return {opRType, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic logic [31:0] iWord(input instOpT op, input int rs, input int rt,
                                          input int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    task automatic appendWord(input int t, input logic [31:0] w);
        progs[t][progLen[t]] = w;
        progLen[t]++;
    endtask

    function automatic int randBelow(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // r0 unless the register was written three or more slots back
    function automatic int pickSource(input int idx);
        int r;
        r = randBelow(9);
        if (lastWrite[r] < 0 || idx - lastWrite[r] < 3)
            r = 0;
        return r;
    endfunction

    task automatic buildPrograms();
        int i;
        int kind;
        int rs;
        int rt;
        int rd;
        foreach (progLen[k])
            progLen[k] = 0;
        foreach (lastWrite[k])
            lastWrite[k] = -1;
        appendWord(0, iWord(opAddi, 0, 1, 25));
        appendWord(0, iWord(opAddi, 0, 2, -7));
        appendWord(0, 32'h0);
        appendWord(0, 32'h0);
        appendWord(0, rWord(fnAdd, 3, 1, 2));
        appendWord(0, rWord(fnSub, 4, 1, 2));
        appendWord(0, rWord(fnAnd, 5, 1, 2));
        appendWord(0, rWord(fnOr, 6, 1, 2));
        appendWord(0, rWord(fnSlt, 7, 2, 1));               // Negative below positive
        appendWord(0, rWord(fnSlt, 8, 1, 2));
        appendWord(0, rWord(fnSlt, 9, 2, 0));
        appendWord(1, iWord(opAddi, 0, 9, -1));
        appendWord(1, iWord(opAddi, 0, 10, -32768));
        appendWord(1, 32'h0);
        appendWord(1, iWord(opAddi, 9, 11, -100));
        appendWord(1, iWord(opAddi, 10, 12, -1));
        appendWord(2, iWord(opAddi, 0, 1, 'h55));
        appendWord(2, iWord(opAddi, 0, 2, -2));
        appendWord(2, 32'h0);
        appendWord(2, iWord(opSw, 0, 1, 16));
        appendWord(2, iWord(opSw, 0, 2, 20));
        appendWord(2, iWord(opSw, 2, 1, 10));               // Negative base gives address 8
        appendWord(2, iWord(opLw, 0, 3, 16));
        appendWord(2, iWord(opLw, 0, 4, 20));
        appendWord(2, iWord(opLw, 0, 5, 8));
        appendWord(3, iWord(opAddi, 0, 1, 5));
        appendWord(3, iWord(opAddi, 0, 2, 5));
        appendWord(3, 32'h0);
        appendWord(3, 32'h0);
        appendWord(3, iWord(opBeq, 1, 2, 3));               // Taken to word 8
        appendWord(3, iWord(opAddi, 0, 3, 1));
        appendWord(3, iWord(opAddi, 0, 4, 2));
        appendWord(3, iWord(opAddi, 0, 5, 99));             // Skipped
        appendWord(3, iWord(opAddi, 0, 6, 3));              // Branch target
        appendWord(3, iWord(opBeq, 1, 0, 3));               // Not taken
        appendWord(3, iWord(opAddi, 0, 7, 4));
        appendWord(3, iWord(opAddi, 0, 8, 5));
        appendWord(3, iWord(opAddi, 0, 9, 6));
        appendWord(4, iWord(opAddi, 0, 0, 77));
        appendWord(4, rWord(fnAdd, 0, 1, 1));
        appendWord(4, 32'h0);
        appendWord(4, iWord(opAddi, 0, 5, 10));
        appendWord(4, rWord(fnOr, 6, 0, 0));
        appendWord(4, iWord(opSw, 0, 0, 32));               // Stores zero
        for (i = 0; i < RAND_LEN; i++) begin
            kind = randBelow(7);
            rs   = pickSource(i);
            rt   = pickSource(i);
            rd   = randBelow(9);
            if (kind < 5)
                appendWord(5, rWord(aluFns[kind], rd, rs, rt));
            else if (kind == 5)
                appendWord(5, iWord(opAddi, rs, rd, randBelow(65536)));
            else
                appendWord(5, iWord(opSw, rs, rt, randBelow(65536)));
            if (kind < 6 && rd != 0)
                lastWrite[rd] = i;
        end
    endtask

    task automatic executeTest(input int t);
        int i;
        testErrors = 0;
        expWb.delete();
        expMem.delete();
        interpretProgram(t);
        for (i = 0; i < progLen[t] + PAD; i++) begin
            @(posedge clk);
            imemWe   <= 1'b1;
            imemAddr <= ADDR_WIDTH'(i * 4);
            imemData <= (i < progLen[t]) ? progs[t][i] : '0;
        end
        @(posedge clk);
        imemWe <= 1'b0;
        run    <= 1'b1;
        repeat (progLen[t] + 10) @(posedge clk);
        run <= 1'b0;
        assert (expWb.size() == 0) else begin
            $display("%s: %0d expected register writes never appeared", testNames[t],
                     expWb.size());
            testErrors++;
        end
        assert (expMem.size() == 0) else begin
            $display("%s: %0d expected stores never appeared", testNames[t], expMem.size());
            testErrors++;
        end
        if (testErrors == 0) begin
            passCount++;
            $display("%-10s passed", testNames[t]);
        end else begin
            failCount++;
            $display("%-10s failed with %0d errors", testNames[t], testErrors);
        end
    endtask

    // Outputs settle after the rising edge and are compared on the falling one
    always @(negedge clk) begin : compare
        logic [REG_WIDTH+DATA_WIDTH-1:0] expW;
        logic [2*DATA_WIDTH-1:0]         expM;
        if (!rst && wb.valid && wb.regWrite) begin
            assert (expWb.size() > 0) else begin
                $display("ERROR @%0t: unexpected write r%0d = %h", $time, wb.destReg, wb.data);
                testErrors++;
            end
            if (expWb.size() > 0) begin
                expW = expWb.pop_front();
                assert ({wb.destReg, wb.data} === expW) else begin
                    $display("ERROR @%0t: write r%0d = %h, expected r%0d = %h", $time,
                             wb.destReg, wb.data, expW[36:32], expW[31:0]);
                    testErrors++;
                end
            end
        end
        if (!rst && memWr.valid) begin
            assert (expMem.size() > 0) else begin
                $display("ERROR @%0t: unexpected store [%h] = %h", $time, memWr.addr,
                         memWr.data);
                testErrors++;
            end
            if (expMem.size() > 0) begin
                expM = expMem.pop_front();
                assert ({memWr.addr, memWr.data} === expM) else begin
                    $display("ERROR @%0t: store [%h] = %h, expected [%h] = %h", $time,
                             memWr.addr, memWr.data, expM[63:32], expM[31:0]);
                    testErrors++;
                end
            end
        end
    end

    initial begin
        int t;
        rst        = 1'b1;
        run        = 1'b0;
        imemWe     = 1'b0;
        imemAddr   = '0;
        imemData   = '0;
        passCount  = 0;
        failCount  = 0;
        testErrors = 0;
        foreach (regModel[k])
            regModel[k] = '0;
        buildPrograms();
        watchLimit = 1000;                                  // Margin for reset and drain
        for (t = 0; t < NUM_TESTS; t++)
            watchLimit += (2 * progLen[t] + PAD + 11) * 40;
        watchArmed = 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        for (t = 0; t < NUM_TESTS; t++)
            executeTest(t);
        $display("Summary: %0d tests passed, %0d failed", passCount, failCount);
        if (failCount == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

    initial begin
        wait (watchArmed);
        #(watchLimit);
        $display("Watchdog expired before the tests finished");
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* design/mipsCore.sv */
`timescale 1ns/100ps

module mipsCore (
    input  logic                            i_clk,
    input  logic                            i_rst,
    input  logic                            i_run,         // Start from address zero
    input  logic                            i_imemWe,
    input  logic [mipsPkg::ADDR_WIDTH-1:0]  i_imemAddr,
    input  mipsPkg::instWordT               i_imemData,
    output mipsPkg::wbT                     o_wb,          // Register write stream
    output mipsPkg::memWrT                  o_memWr        // Store stream
);
    import mipsPkg::*;

    ifIdT   ifId;
    idExT   idEx;
    exMemT  exMem;
    branchT branch;

    stageIF fetch (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_run      (i_run),
        .i_imemWe   (i_imemWe),
        .i_imemAddr (i_imemAddr),
        .i_imemData (i_imemData),
        .i_branch   (branch),
        .o_ifId     (ifId)
    );

    stageID decode (
        .i_clk  (i_clk),
        .i_rst  (i_rst),
        .i_ifId (ifId),
        .i_wb   (o_wb),                                    // Write-back closes the loop here
        .o_idEx (idEx)
    );

    stageEX execute (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_idEx   (idEx),
        .o_exMem  (exMem),
        .o_branch (branch)
    );

    stageMEM memory (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_exMem (exMem),
        .o_wb    (o_wb),
        .o_memWr (o_memWr)
    );

endmodule

/* design/stageMEM.sv */
`timescale 1ns/100ps

module stageMEM (
    input  logic              i_clk,
    input  logic              i_rst,
    input  mipsPkg::exMemT    i_exMem,
    output mipsPkg::wbT       o_wb,
    output mipsPkg::memWrT    o_memWr                      // Store seen by data memory
);
    import mipsPkg::*;

    logic [DATA_WIDTH-1:0]     dmem [DMEM_WORDS];
    logic [DMEM_ADDR_BITS-1:0] wordIdx;
    logic                      storeEn;
    logic [DATA_WIDTH-1:0]     loadData;

    assign wordIdx  = i_exMem.aluResult[DMEM_ADDR_BITS+1:2];  // Upper bits ignored
    assign storeEn  = i_exMem.valid & i_exMem.memWrite;
    assign loadData = dmem[wordIdx];

    always_ff @(posedge i_clk) begin
        if (storeEn)
            dmem[wordIdx] <= i_exMem.storeData;
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_memWr.valid <= 1'b0;
            o_wb.valid    <= 1'b0;
            o_wb.regWrite <= 1'b0;
        end else begin
            o_memWr.valid <= storeEn;                      // Same edge as the array write
            o_wb.valid    <= i_exMem.valid;
            o_wb.regWrite <= i_exMem.regWrite;
        end
        o_memWr.addr <= i_exMem.aluResult;
        o_memWr.data <= i_exMem.storeData;
        o_wb.destReg <= i_exMem.destReg;
        o_wb.data    <= i_exMem.memToReg ? loadData : i_exMem.aluResult;
    end

endmodule

/* design/stageEX.sv */
`timescale 1ns/100ps

module stageEX (
    input  logic              i_clk,
    input  logic              i_rst,
    input  mipsPkg::idExT     i_idEx,
    output mipsPkg::exMemT    o_exMem,
    output mipsPkg::branchT   o_branch                     // Combinational, back to fetch
);
    import mipsPkg::*;

    logic [DATA_WIDTH-1:0] opA;
    logic [DATA_WIDTH-1:0] opB;
    logic [DATA_WIDTH-1:0] aluResult;
    logic                  aluZero;
    logic [REG_WIDTH-1:0]  destReg;

    assign opA = i_idEx.dataA;
    assign opB = i_idEx.aluSrcB ? i_idEx.imm : i_idEx.dataB;

    always_comb begin
        case (i_idEx.aluCtrl)
            aluAnd:  aluResult = opA & opB;
            aluOr:   aluResult = opA | opB;
            aluAdd:  aluResult = opA + opB;
            aluSub:  aluResult = opA - opB;
            aluSlt:  aluResult = {{(DATA_WIDTH-1){1'b0}}, $signed(opA) < $signed(opB)};
            default: aluResult = '0;
        endcase
    end

    assign aluZero = (aluResult == '0);
    assign destReg = i_idEx.regDst ? i_idEx.rd : i_idEx.rt;

    // beq subtracts, so a zero result means equal operands
    assign o_branch.taken  = i_idEx.valid & i_idEx.branch & aluZero;
    assign o_branch.target = i_idEx.pcPlus4 + {i_idEx.imm[ADDR_WIDTH-3:0], 2'b00};

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_exMem.valid    <= 1'b0;
            o_exMem.regWrite <= 1'b0;
            o_exMem.memWrite <= 1'b0;
            o_exMem.memToReg <= 1'b0;
        end else begin
            o_exMem.valid    <= i_idEx.valid;
            o_exMem.regWrite <= i_idEx.regWrite;          // Already cleared for bubbles
            o_exMem.memWrite <= i_idEx.memWrite;
            o_exMem.memToReg <= i_idEx.memToReg;
        end
        o_exMem.aluResult <= aluResult;
        o_exMem.storeData <= i_idEx.dataB;                 // rt value for sw
        o_exMem.destReg   <= destReg;
    end

endmodule

/* design/stageIF.sv */
`timescale 1ns/100ps

module stageIF (
    input  logic                            i_clk,
    input  logic                            i_rst,
    input  logic                            i_run,         // Low holds PC at zero
    input  logic                            i_imemWe,
    input  logic [mipsPkg::ADDR_WIDTH-1:0]  i_imemAddr,    // Byte address of loaded word
    input  mipsPkg::instWordT               i_imemData,
    input  mipsPkg::branchT                 i_branch,      // Redirect from execute
    output mipsPkg::ifIdT                   o_ifId
);
    import mipsPkg::*;

    instWordT                  imem [IMEM_WORDS];
    logic [ADDR_WIDTH-1:0]     pc;
    logic [ADDR_WIDTH-1:0]     pcPlus4;
    logic [IMEM_ADDR_BITS-1:0] pcIdx;
    logic [IMEM_ADDR_BITS-1:0] loadIdx;

    assign pcPlus4 = pc + ADDR_WIDTH'(4);
    assign pcIdx   = pc[IMEM_ADDR_BITS+1:2];
    assign loadIdx = i_imemAddr[IMEM_ADDR_BITS+1:2];

    always_ff @(posedge i_clk) begin
        if (i_imemWe)
            imem[loadIdx] <= i_imemData;                   // Program load port
    end

    always_ff @(posedge i_clk) begin
        if (i_rst || !i_run)
            pc <= '0;
        else if (i_branch.taken)
            pc <= i_branch.target;                         // Two delay slots already fetched
        else
            pc <= pcPlus4;
    end

    always_ff @(posedge i_clk) begin
        if (i_rst)
            o_ifId.valid <= 1'b0;
        else
            o_ifId.valid <= i_run;
        o_ifId.inst    <= i_run ? imem[pcIdx] : '0;        // Nop while idle
        o_ifId.pcPlus4 <= pcPlus4;
    end

endmodule

/* stageID/stageID.sv */
`timescale 1ns/100ps

module stageID (
    input  logic            i_clk,
    input  logic            i_rst,
    input  mipsPkg::ifIdT   i_ifId,                        // Fetched word
    input  mipsPkg::wbT     i_wb,                          // Register write from write-back
    output mipsPkg::idExT   o_idEx
);
    import mipsPkg::*;

    instWordT              inst;
    logic [DATA_WIDTH-1:0] imm;
    logic [DATA_WIDTH-1:0] dataA;
    logic [DATA_WIDTH-1:0] dataB;
    aluCtrlT               aluCtrl;
    logic                  aluSrcB;
    logic                  memWrite;
    logic                  regWrite;
    logic                  regDst;
    logic                  memToReg;
    logic                  branch;
    logic                  regWe;

    assign inst  = i_ifId.inst;
    assign imm   = {{(DATA_WIDTH-16){inst.i.imm[15]}}, inst.i.imm};  // Sign extension
    assign regWe = i_wb.valid & i_wb.regWrite;

    controller ctrl (
        .i_op       (inst.i.op),
        .i_fn       (inst.r.fn),
        .o_aluCtrl  (aluCtrl),
        .o_aluSrcB  (aluSrcB),
        .o_memWrite (memWrite),
        .o_regWrite (regWrite),
        .o_regDst   (regDst),
        .o_memToReg (memToReg),
        .o_branch   (branch)
    );

    regFile regs (
        .i_clk    (i_clk),
        .i_we     (regWe),
        .i_rAddrA (inst.i.rs),
        .i_rAddrB (inst.i.rt),
        .i_wAddr  (i_wb.destReg),
        .i_wData  (i_wb.data),
        .o_rDataA (dataA),
        .o_rDataB (dataB)
    );

    always_ff @(posedge i_clk) begin
        if (i_rst || !i_ifId.valid) begin                  // Bubble carries no effects
            o_idEx.valid    <= 1'b0;
            o_idEx.regWrite <= 1'b0;
            o_idEx.memWrite <= 1'b0;
            o_idEx.memToReg <= 1'b0;
            o_idEx.regDst   <= 1'b0;
            o_idEx.aluSrcB  <= 1'b0;
            o_idEx.aluCtrl  <= aluAdd;
            o_idEx.branch   <= 1'b0;
        end else begin
            o_idEx.valid    <= 1'b1;
            o_idEx.regWrite <= regWrite;
            o_idEx.memWrite <= memWrite;
            o_idEx.memToReg <= memToReg;
            o_idEx.regDst   <= regDst;
            o_idEx.aluSrcB  <= aluSrcB;
            o_idEx.aluCtrl  <= aluCtrl;
            o_idEx.branch   <= branch;
        end
        o_idEx.dataA   <= dataA;
        o_idEx.dataB   <= dataB;
        o_idEx.rt      <= inst.i.rt;
        o_idEx.rd      <= inst.r.rd;                       // Only meaningful for R-type
        o_idEx.imm     <= imm;
        o_idEx.pcPlus4 <= i_ifId.pcPlus4;
    end

endmodule

/* stageID/regFile.sv */
`timescale 1ns/100ps

module regFile (
    input  logic                            i_clk,
    input  logic                            i_we,
    input  logic [mipsPkg::REG_WIDTH-1:0]   i_rAddrA,
    input  logic [mipsPkg::REG_WIDTH-1:0]   i_rAddrB,
    input  logic [mipsPkg::REG_WIDTH-1:0]   i_wAddr,
    input  logic [mipsPkg::DATA_WIDTH-1:0]  i_wData,
    output logic [mipsPkg::DATA_WIDTH-1:0]  o_rDataA,
    output logic [mipsPkg::DATA_WIDTH-1:0]  o_rDataB
);
    import mipsPkg::*;

    logic [DATA_WIDTH-1:0] regs [2**REG_WIDTH];            // Entry 0 never written

    // Read port with r0 forced to zero and write-first bypass
    function automatic logic [DATA_WIDTH-1:0] readPort(
        input logic [REG_WIDTH-1:0]  addr,
        input logic [DATA_WIDTH-1:0] stored,
        input logic                  we,
        input logic [REG_WIDTH-1:0]  wAddr,
        input logic [DATA_WIDTH-1:0] wData
    );
        if (addr == '0)
            return '0;
        else if (we && addr == wAddr)
            return wData;                                  // Same-cycle write-back
        else
            return stored;
    endfunction

    always_ff @(posedge i_clk) begin
        if (i_we && i_wAddr != '0)
            regs[i_wAddr] <= i_wData;
    end

    assign o_rDataA = readPort(i_rAddrA, regs[i_rAddrA], i_we, i_wAddr, i_wData);
    assign o_rDataB = readPort(i_rAddrB, regs[i_rAddrB], i_we, i_wAddr, i_wData);

endmodule

/* stageID/controller.sv */
`timescale 1ns/100ps

module controller (
    input  mipsPkg::instOpT   i_op,
    input  mipsPkg::instFnT   i_fn,
    output mipsPkg::aluCtrlT  o_aluCtrl,
    output logic              o_aluSrcB,                   // Immediate as operand B
    output logic              o_memWrite,
    output logic              o_regWrite,
    output logic              o_regDst,                    // Write rd instead of rt
    output logic              o_memToReg,                  // Write back load data
    output logic              o_branch
);
    import mipsPkg::*;

    always_comb begin
        o_aluCtrl  = aluAdd;                               // Safe defaults, no side effects
        o_aluSrcB  = 1'b0;
        o_memWrite = 1'b0;
        o_regWrite = 1'b0;
        o_regDst   = 1'b0;
        o_memToReg = 1'b0;
        o_branch   = 1'b0;

        case (i_op)
            opRType: begin
                o_regDst   = 1'b1;
                o_regWrite = 1'b1;
                case (i_fn)
                    fnAdd:   o_aluCtrl = aluAdd;
                    fnSub:   o_aluCtrl = aluSub;
                    fnAnd:   o_aluCtrl = aluAnd;
                    fnOr:    o_aluCtrl = aluOr;
                    fnSlt:   o_aluCtrl = aluSlt;
                    fnNop:   o_regWrite = 1'b0;            // All-zero word
                    default: o_regWrite = 1'b0;            // Unsupported function
                endcase
            end
            opAddi: begin
                o_aluSrcB  = 1'b1;
                o_regWrite = 1'b1;
            end
            opLw: begin
                o_aluSrcB  = 1'b1;                         // Base plus offset
                o_regWrite = 1'b1;
                o_memToReg = 1'b1;
            end
            opSw: begin
                o_aluSrcB  = 1'b1;
                o_memWrite = 1'b1;
            end
            opBeq: begin
                o_aluCtrl = aluSub;                        // Equal when result is zero
                o_branch  = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

/* common/mipsPkg.sv */
package mipsPkg;

    localparam int DATA_WIDTH     = 32;                    // Data word
    localparam int ADDR_WIDTH     = 32;                    // Instruction address
    localparam int REG_WIDTH      = 5;                     // Register index
    localparam int IMEM_WORDS     = 256;                   // Instruction memory depth
    localparam int DMEM_WORDS     = 64;                    // Data memory depth
    localparam int IMEM_ADDR_BITS = $clog2(IMEM_WORDS);    // Word index into instruction memory
    localparam int DMEM_ADDR_BITS = $clog2(DMEM_WORDS);    // Word index into data memory

    typedef enum logic [5:0] {
        opRType = 6'h00,
        opBeq   = 6'h04,
        opAddi  = 6'h08,
        opLw    = 6'h23,
        opSw    = 6'h2b
    } instOpT;

    typedef enum logic [5:0] {
        fnNop = 6'h00,                                     // Also the all-zero word
        fnAdd = 6'h20,
        fnSub = 6'h22,
        fnAnd = 6'h24,
        fnOr  = 6'h25,
        fnSlt = 6'h2a
    } instFnT;

    typedef enum logic [2:0] {
        aluAnd = 3'b000,
        aluOr  = 3'b001,
        aluAdd = 3'b010,
        aluSub = 3'b110,
        aluSlt = 3'b111
    } aluCtrlT;

    typedef struct packed {
        instOpT                op;
        logic [REG_WIDTH-1:0]  rs;
        logic [REG_WIDTH-1:0]  rt;
        logic [REG_WIDTH-1:0]  rd;
        logic [4:0]            shamt;                      // Ignored, no shifts
        instFnT                fn;
    } rTypeT;

    typedef struct packed {
        instOpT                op;
        logic [REG_WIDTH-1:0]  rs;
        logic [REG_WIDTH-1:0]  rt;
        logic [15:0]           imm;
    } iTypeT;

    // One instruction word, read through whichever layout the opcode implies
    typedef union packed {
        rTypeT r;
        iTypeT i;
    } instWordT;

    typedef struct packed {
        logic                  valid;
        instWordT              inst;
        logic [ADDR_WIDTH-1:0] pcPlus4;
    } ifIdT;

    typedef struct packed {
        logic                  valid;
        logic [DATA_WIDTH-1:0] dataA;
        logic [DATA_WIDTH-1:0] dataB;
        logic [REG_WIDTH-1:0]  rt;
        logic [REG_WIDTH-1:0]  rd;
        logic [DATA_WIDTH-1:0] imm;                        // Already sign-extended
        logic [ADDR_WIDTH-1:0] pcPlus4;
        logic                  regWrite;
        logic                  memWrite;
        logic                  memToReg;
        logic                  regDst;                     // 1 selects rd
        logic                  aluSrcB;                    // 1 selects imm
        aluCtrlT               aluCtrl;
        logic                  branch;
    } idExT;

    typedef struct packed {
        logic                  valid;
        logic [DATA_WIDTH-1:0] aluResult;
        logic [DATA_WIDTH-1:0] storeData;
        logic [REG_WIDTH-1:0]  destReg;
        logic                  regWrite;
        logic                  memWrite;
        logic                  memToReg;
    } exMemT;

    typedef struct packed {
        logic                  valid;
        logic                  regWrite;
        logic [REG_WIDTH-1:0]  destReg;
        logic [DATA_WIDTH-1:0] data;
    } wbT;

    typedef struct packed {
        logic                  valid;
        logic [DATA_WIDTH-1:0] addr;                       // Byte address
        logic [DATA_WIDTH-1:0] data;
    } memWrT;

    typedef struct packed {
        logic                  taken;
        logic [ADDR_WIDTH-1:0] target;
    } branchT;

endpackage
